/* umi_params.svh */
/* Widths, FIFO depth and APB register addresses for the UMI clock-crossing design
   UMI_FIFO_DEPTH must be a power of two and at least 4 */
`ifndef UMI_PARAMS_SVH
`define UMI_PARAMS_SVH

// UMI packet field widths
`define UMI_CW 32            // Command word
`define UMI_AW 64            // Destination and source address
`define UMI_DW 64            // Data word

// Clock-crossing FIFO entries
`define UMI_FIFO_DEPTH 4

// APB bus
`define UMI_APB_AW 8
`define UMI_APB_DW 32

// Register map, one 32-bit word each
`define UMI_CSR_CTRL_ADDR      8'h00
`define UMI_CSR_STATUS_ADDR    8'h04
`define UMI_CSR_CNT_REQ_ADDR   8'h08
`define UMI_CSR_CNT_RESP_ADDR  8'h0C
`define UMI_CSR_CNT_OTHER_ADDR 8'h10

`endif

/* umi_pkg.sv */
/* Shared UMI types for the clock-crossing design
   Opcode lives in cmd[7:0], all other cmd bits pass through untouched */
`include "umi_params.svh"

package umi_pkg;

   // One UMI packet, cmd sits in the top bits
   typedef struct packed {
      logic [`UMI_CW-1:0] cmd;
      logic [`UMI_AW-1:0] dstaddr;
      logic [`UMI_AW-1:0] srcaddr;
      logic [`UMI_DW-1:0] data;
   } umi_pkt_t;

   // Opcodes in the low byte of cmd
   typedef enum logic [7:0] {
      UMI_REQ_READ   = 8'h01,
      UMI_RESP_READ  = 8'h02,
      UMI_REQ_WRITE  = 8'h03,
      UMI_RESP_WRITE = 8'h04,
      UMI_REQ_POSTED = 8'h05
   } umi_opcode_e;

   // APB register map
   typedef enum logic [`UMI_APB_AW-1:0] {
      CSR_CTRL      = `UMI_CSR_CTRL_ADDR,
      CSR_STATUS    = `UMI_CSR_STATUS_ADDR,
      CSR_CNT_REQ   = `UMI_CSR_CNT_REQ_ADDR,
      CSR_CNT_RESP  = `UMI_CSR_CNT_RESP_ADDR,
      CSR_CNT_OTHER = `UMI_CSR_CNT_OTHER_ADDR
   } umi_csr_addr_e;

   // CSR_CTRL layout, bit 0 is bypass
   typedef struct packed {
      logic chaosmode;       // Random FIFO push-back
      logic bypass;          // Skip the FIFO
   } umi_csr_ctrl_t;

endpackage

/* umi_async_fifo.sv */
/* Dual-clock FIFO with first-word fall-through read data; DEPTH is a power of two, 4 or more
   wr_chaosmode is sampled in the write domain and must be quasi-static
   wr_full and fifo_full_rd are pessimistic by the synchronizer delay */
`timescale 1ns/1ps
`include "umi_params.svh"

module umi_async_fifo #(
   parameter int DEPTH = `UMI_FIFO_DEPTH
) (
   // Write domain
   input  logic              wr_clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  umi_pkg::umi_pkt_t wr_din,
   input  logic              wr_chaosmode,
   output logic              wr_full,
   // Read domain
   input  logic              rd_clk,
   input  logic              rd_en,
   output umi_pkg::umi_pkt_t rd_dout,
   output logic              rd_empty,
   output logic              fifo_full_rd
);

   localparam int PW = $clog2(DEPTH);   // Index bits, pointers carry one extra wrap bit

   umi_pkg::umi_pkt_t mem [DEPTH];      // Packet storage

   logic [PW:0] wr_bin;
   logic [PW:0] wr_bin_nxt;
   logic [PW:0] wr_gray;
   logic [PW:0] rd_bin;
   logic [PW:0] rd_bin_nxt;
   logic [PW:0] rd_gray;
   logic [PW:0] rd_gray_s1;             // Read pointer, first sync flop
   logic [PW:0] rd_gray_s2;             // Read pointer as seen by writer
   logic [PW:0] wr_gray_s1;             // Write pointer, first sync flop
   logic [PW:0] wr_gray_s2;             // Write pointer as seen by reader
   logic [7:0]  lfsr;
   logic        full_ptr;
   logic        chaos_hold;
   logic        wr_push;
   logic        rd_pop;

   function automatic logic [PW:0] bin2gray(input logic [PW:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   //######################################
   // Write domain
   //######################################

   // Full when top two Gray bits differ and the rest match
   assign full_ptr   = (wr_gray == {~rd_gray_s2[PW:PW-1], rd_gray_s2[PW-2:0]});
   assign chaos_hold = wr_chaosmode & (lfsr[1:0] == 2'b11);   // About one cycle in four
   assign wr_full    = full_ptr | chaos_hold;
   assign wr_push    = wr_en & ~wr_full;                       // Blocked while full
   assign wr_bin_nxt = wr_bin + {{PW{1'b0}}, wr_push};

   always_ff @(posedge wr_clk) begin
      if (!rst_n) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
         lfsr       <= 8'h01;       // Any nonzero seed
      end else begin
         wr_bin     <= wr_bin_nxt;
         wr_gray    <= bin2gray(wr_bin_nxt);
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
         // x^8 + x^6 + x^5 + x^4 + 1
         lfsr       <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_push) mem[wr_bin[PW-1:0]] <= wr_din;
   end

   //######################################
   // Read domain
   //######################################

   assign rd_empty   = (rd_gray == wr_gray_s2);
   assign rd_pop     = rd_en & ~rd_empty;                      // Blocked while empty
   assign rd_bin_nxt = rd_bin + {{PW{1'b0}}, rd_pop};
   assign rd_dout    = mem[rd_bin[PW-1:0]];                    // Head of queue

   // Full status from the reader's view, for the CSR
   assign fifo_full_rd = (wr_gray_s2 == {~rd_gray[PW:PW-1], rd_gray[PW-2:0]});

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         rd_bin     <= rd_bin_nxt;
         rd_gray    <= bin2gray(rd_bin_nxt);
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

endmodule

/* umi_fifo.sv */
/* UMI clock-crossing stage around the dual-clock FIFO
   bypass joins both domains combinationally and needs both clocks from one source
   fifo_full and fifo_empty are in the umi_out_clk domain */
`timescale 1ns/1ps

module umi_fifo (
   input  logic              umi_in_clk,
   input  logic              umi_out_clk,
   input  logic              rst_n,
   // Control
   input  logic              bypass,
   input  logic              chaosmode,
   // Input side
   input  logic              in_valid,
   input  umi_pkg::umi_pkt_t in_pkt,
   output logic              in_ready,
   // Output side
   output logic              out_valid,
   output umi_pkg::umi_pkt_t out_pkt,
   input  logic              out_ready,
   // Status
   output logic              fifo_full,
   output logic              fifo_empty
);

   umi_pkg::umi_pkt_t fifo_dout;
   logic              fifo_wr_full;   // Write-side full, includes chaos push-back
   logic              fifo_wr;
   logic              fifo_rd;

   // Push on a valid input while room, never in bypass
   assign fifo_wr = in_valid & ~fifo_wr_full & ~bypass;

   // Pop when downstream takes the head entry
   assign fifo_rd = ~fifo_empty & out_ready & ~bypass;

   umi_async_fifo fifo (
      .wr_clk       (umi_in_clk),
      .rst_n        (rst_n),
      .wr_en        (fifo_wr),
      .wr_din       (in_pkt),
      .wr_chaosmode (chaosmode),
      .wr_full      (fifo_wr_full),
      .rd_clk       (umi_out_clk),
      .rd_en        (fifo_rd),
      .rd_dout      (fifo_dout),
      .rd_empty     (fifo_empty),
      .fifo_full_rd (fifo_full)
   );

   // Bypass mux, handshake goes straight through
   assign out_pkt   = bypass ? in_pkt    : fifo_dout;
   assign out_valid = bypass ? in_valid  : ~fifo_empty;
   assign in_ready  = bypass ? out_ready : ~fifo_wr_full;

endmodule

/* umi_skid_buffer.sv */
/* Two-entry UMI register slice, full throughput under back-pressure
   in_ready comes from a flop and never depends on out_ready in the same cycle */
`timescale 1ns/1ps

module umi_skid_buffer (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid,
   input  umi_pkg::umi_pkt_t in_pkt,
   output logic              in_ready,
   output logic              out_valid,
   output umi_pkg::umi_pkt_t out_pkt,
   input  logic              out_ready
);

   umi_pkg::umi_pkt_t main_pkt;    // Presented at the output
   umi_pkg::umi_pkt_t skid_pkt;    // Catches the beat taken during a stall
   logic              main_valid;
   logic              skid_valid;
   logic              in_beat;
   logic              main_free;

   assign in_ready  = ~skid_valid;                // Registered ready
   assign in_beat   = in_valid & in_ready;
   assign main_free = ~main_valid | out_ready;    // Main drains or is empty

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else if (main_free) begin
         main_valid <= skid_valid | in_beat;
         skid_valid <= 1'b0;                      // Skid always empties into main
      end else if (in_beat) begin
         skid_valid <= 1'b1;                      // Output stalled, park the beat
      end
   end

   always_ff @(posedge clk) begin
      if (main_free) begin
         if (skid_valid) main_pkt <= skid_pkt;    // Older packet first
         else if (in_beat) main_pkt <= in_pkt;
      end
      if (!main_free && in_beat) skid_pkt <= in_pkt;
   end

   assign out_valid = main_valid;
   assign out_pkt   = main_pkt;

endmodule

/* umi_fifo_csr.sv */
/* APB control and status registers for the UMI FIFO, no wait states
   Counters see one beat per cycle, wrap at 2**32, and clear on any write */
`timescale 1ns/1ps
`include "umi_params.svh"

module umi_fifo_csr (
   input  logic                   clk,
   input  logic                   rst_n,
   // APB slave
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`UMI_APB_AW-1:0] paddr,
   input  logic [`UMI_APB_DW-1:0] pwdata,
   output logic [`UMI_APB_DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   // Output beat monitor
   input  logic                   beat_valid,
   input  logic [`UMI_CW-1:0]     beat_cmd,
   // FIFO status and control
   input  logic                   fifo_full,
   input  logic                   fifo_empty,
   output logic                   bypass,
   output logic                   chaosmode
);

   localparam int         NCLS      = 3;
   localparam logic [1:0] CLS_REQ   = 2'd0;
   localparam logic [1:0] CLS_RESP  = 2'd1;
   localparam logic [1:0] CLS_OTHER = 2'd2;

   umi_pkg::umi_csr_ctrl_t ctrl_q;
   logic [31:0]            cnt_q [NCLS];  // Indexed by class
   logic [NCLS-1:0]        cnt_clr;
   logic [1:0]             beat_cls;
   logic                   apb_write;
   logic                   ctrl_wr;
   logic                   addr_hit;

   assign pready    = 1'b1;                       // Never stalls
   assign apb_write = psel & penable & pwrite;
   assign pslverr   = psel & penable & ~addr_hit;

   //######################################
   // Address decode and read mux
   //######################################

   always_comb begin
      addr_hit = 1'b1;
      ctrl_wr  = 1'b0;
      cnt_clr  = '0;
      prdata   = '0;
      case (paddr)
         umi_pkg::CSR_CTRL: begin
            ctrl_wr     = apb_write;
            prdata[1:0] = ctrl_q;
         end
         umi_pkg::CSR_STATUS: begin
            prdata[0] = fifo_full;
            prdata[1] = fifo_empty;
         end
         umi_pkg::CSR_CNT_REQ: begin
            cnt_clr[CLS_REQ] = apb_write;
            prdata           = cnt_q[CLS_REQ];
         end
         umi_pkg::CSR_CNT_RESP: begin
            cnt_clr[CLS_RESP] = apb_write;
            prdata            = cnt_q[CLS_RESP];
         end
         umi_pkg::CSR_CNT_OTHER: begin
            cnt_clr[CLS_OTHER] = apb_write;
            prdata             = cnt_q[CLS_OTHER];
         end
         default: addr_hit = 1'b0;   // Unmapped, write dropped
      endcase
   end

   // Opcode class of the current output beat
   always_comb begin
      beat_cls = CLS_OTHER;
      case (umi_pkg::umi_opcode_e'(beat_cmd[7:0]))
         umi_pkg::UMI_REQ_READ,
         umi_pkg::UMI_REQ_WRITE,
         umi_pkg::UMI_REQ_POSTED: beat_cls = CLS_REQ;
         umi_pkg::UMI_RESP_READ,
         umi_pkg::UMI_RESP_WRITE: beat_cls = CLS_RESP;
         default:                 beat_cls = CLS_OTHER;
      endcase
   end

   //######################################
   // Registers
   //######################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_q <= '0;
         for (int i = 0; i < NCLS; i++) cnt_q[i] <= '0;
      end else begin
         if (ctrl_wr) ctrl_q <= pwdata[1:0];
         for (int i = 0; i < NCLS; i++) begin
            if (cnt_clr[i]) cnt_q[i] <= '0;                    // Clear wins over count
            else if (beat_valid && beat_cls == i[1:0]) cnt_q[i] <= cnt_q[i] + 32'd1;
         end
      end
   end

   assign bypass    = ctrl_q.bypass;
   assign chaosmode = ctrl_q.chaosmode;

endmodule

/* umi_fifo_top.sv */
/* UMI clock-crossing subsystem: FIFO, output register slice and APB registers
   APB runs on umi_out_clk; bypass is legal only with both clocks from one source
   rst_n must be held low across edges of both clocks */
`timescale 1ns/1ps
`include "umi_params.svh"

module umi_fifo_top (
   input  logic                   umi_in_clk,
   input  logic                   umi_out_clk,
   input  logic                   rst_n,
   // UMI input, umi_in_clk domain
   input  logic                   umi_in_valid,
   input  umi_pkg::umi_pkt_t      umi_in_pkt,
   output logic                   umi_in_ready,
   // UMI output, umi_out_clk domain
   output logic                   umi_out_valid,
   output umi_pkg::umi_pkt_t      umi_out_pkt,
   input  logic                   umi_out_ready,
   // APB slave, umi_out_clk domain
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`UMI_APB_AW-1:0] paddr,
   input  logic [`UMI_APB_DW-1:0] pwdata,
   output logic [`UMI_APB_DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr
);

   umi_pkg::umi_pkt_t fifo_out_pkt;
   logic              fifo_out_valid;
   logic              fifo_out_ready;   // From the skid buffer, registered
   logic              fifo_full;
   logic              fifo_empty;
   logic              bypass;
   logic              chaosmode;

   //######################################
   // UMI datapath
   //######################################

   umi_fifo fifo (
      .umi_in_clk  (umi_in_clk),
      .umi_out_clk (umi_out_clk),
      .rst_n       (rst_n),
      .bypass      (bypass),
      .chaosmode   (chaosmode),
      .in_valid    (umi_in_valid),
      .in_pkt      (umi_in_pkt),
      .in_ready    (umi_in_ready),
      .out_valid   (fifo_out_valid),
      .out_pkt     (fifo_out_pkt),
      .out_ready   (fifo_out_ready),
      .fifo_full   (fifo_full),
      .fifo_empty  (fifo_empty)
   );

   umi_skid_buffer skid (
      .clk       (umi_out_clk),
      .rst_n     (rst_n),
      .in_valid  (fifo_out_valid),
      .in_pkt    (fifo_out_pkt),
      .in_ready  (fifo_out_ready),
      .out_valid (umi_out_valid),
      .out_pkt   (umi_out_pkt),
      .out_ready (umi_out_ready)
   );

   //######################################
   // Control registers
   //######################################

   umi_fifo_csr csr (
      .clk        (umi_out_clk),
      .rst_n      (rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .beat_valid (umi_out_valid & umi_out_ready),   // Delivered beat
      .beat_cmd   (umi_out_pkt.cmd),
      .fifo_full  (fifo_full),
      .fifo_empty (fifo_empty),
      .bypass     (bypass),
      .chaosmode  (chaosmode)
   );

endmodule

/* tb_umi_fifo_assertions.sv */
/* UMI and APB protocol assertions, bound into umi_fifo_top
   Handshake checks are off while rst_n is low */
`timescale 1ns/1ps

module tb_umi_fifo_assertions (
   input logic              umi_in_clk,
   input logic              umi_out_clk,
   input logic              rst_n,
   input logic              umi_in_valid,
   input umi_pkg::umi_pkt_t umi_in_pkt,
   input logic              umi_in_ready,
   input logic              umi_out_valid,
   input umi_pkg::umi_pkt_t umi_out_pkt,
   input logic              umi_out_ready,
   input logic              psel,
   input logic              penable
);

   // Input link, held until the beat
   a_in_valid_hold: assert property (@(posedge umi_in_clk) disable iff (!rst_n)
      umi_in_valid && !umi_in_ready |=> umi_in_valid)
      else $error("umi_in_valid dropped before its beat");
   a_in_pkt_hold: assert property (@(posedge umi_in_clk) disable iff (!rst_n)
      umi_in_valid && !umi_in_ready |=> $stable(umi_in_pkt))
      else $error("umi_in_pkt changed while waiting for ready");

   // Output link
   a_out_valid_hold: assert property (@(posedge umi_out_clk) disable iff (!rst_n)
      umi_out_valid && !umi_out_ready |=> umi_out_valid)
      else $error("umi_out_valid dropped before its beat");
   a_out_pkt_hold: assert property (@(posedge umi_out_clk) disable iff (!rst_n)
      umi_out_valid && !umi_out_ready |=> $stable(umi_out_pkt))
      else $error("umi_out_pkt changed while waiting for ready");

   // APB phases
   a_penable_sel: assert property (@(posedge umi_out_clk) disable iff (!rst_n)
      penable |-> psel)
      else $error("penable high without psel");
   a_penable_setup: assert property (@(posedge umi_out_clk) disable iff (!rst_n)
      $rose(penable) |-> $past(psel))
      else $error("penable rose without a setup phase");

   a_out_reset: assert property (@(posedge umi_out_clk) !rst_n |=> !umi_out_valid)
      else $error("umi_out_valid high after reset");

endmodule

/* tb_umi_fifo.sv */
/* Directed testbench for the UMI clock-crossing subsystem, both clocks from one source
   Inputs change on the falling edge, flop outputs are sampled there too
   APB read data is sampled a quarter period before the completing edge */
`timescale 1ns/1ps
`include "umi_params.svh"

module tb_umi_fifo;

   localparam int HALF      = 4;      // 8 ns clock
   localparam int TIMEOUT   = 200;    // Cycles without progress
   localparam int STALL_RUN = 8;      // Low ready cycles that count as a settled stall

   logic                   clk;
   logic                   rst_n;
   logic                   umi_in_valid;
   umi_pkg::umi_pkt_t      umi_in_pkt;
   logic                   umi_in_ready;
   logic                   umi_out_valid;
   umi_pkg::umi_pkt_t      umi_out_pkt;
   logic                   umi_out_ready;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`UMI_APB_AW-1:0] paddr;
   logic [`UMI_APB_DW-1:0] pwdata;
   logic [`UMI_APB_DW-1:0] prdata;
   logic                   pready;
   logic                   pslverr;

   umi_pkg::umi_pkt_t to_send [$];    // Waiting for an input beat
   umi_pkg::umi_pkt_t expected [$];   // Scoreboard, accepted but not yet delivered
   logic [15:0]       lfsr_state;
   logic              last_slverr;
   int                errors;
   int                errors_at_start;
   int                tests_run;
   int                tests_failed;
   string             cur_test;

   umi_fifo_top UUT (
      .umi_in_clk    (clk),
      .umi_out_clk   (clk),           // Same source, bypass is legal
      .rst_n         (rst_n),
      .umi_in_valid  (umi_in_valid),
      .umi_in_pkt    (umi_in_pkt),
      .umi_in_ready  (umi_in_ready),
      .umi_out_valid (umi_out_valid),
      .umi_out_pkt   (umi_out_pkt),
      .umi_out_ready (umi_out_ready),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr)
   );

   bind umi_fifo_top tb_umi_fifo_assertions checks (
      .umi_in_clk    (umi_in_clk),
      .umi_out_clk   (umi_out_clk),
      .rst_n         (rst_n),
      .umi_in_valid  (umi_in_valid),
      .umi_in_pkt    (umi_in_pkt),
      .umi_in_ready  (umi_in_ready),
      .umi_out_valid (umi_out_valid),
      .umi_out_pkt   (umi_out_pkt),
      .umi_out_ready (umi_out_ready),
      .psel          (psel),
      .penable       (penable)
   );

   always #HALF clk = ~clk;

   //########################################
   // Random source and packet builder
   //########################################

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic lfsr_bit();
      logic fb;
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[62:0], lfsr_bit()};
      return v;
   endfunction

   function automatic umi_pkg::umi_pkt_t make_pkt(input logic [7:0] opcode);
      umi_pkg::umi_pkt_t p;
      logic [63:0]       upper;
      upper     = rand_bits(24);
      p.cmd     = {upper[23:0], opcode};    // Opcode in the low byte
      p.dstaddr = rand_bits(64);
      p.srcaddr = rand_bits(64);
      p.data    = rand_bits(64);
      return p;
   endfunction

   //########################################
   // Checks and reporting
   //########################################

   task automatic report_error(input string msg);
      errors++;
      $display("Error in %s: %s", cur_test, msg);
   endtask

   task automatic check_pkt(input umi_pkg::umi_pkt_t exp, input umi_pkg::umi_pkt_t act);
      if (exp !== act) begin
         errors++;
         $display("Fail %s: expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("Fail %s: expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      cur_test        = name;
      errors_at_start = errors;
      tests_run++;
   endtask

   task automatic finish_test();
      if (expected.size() != 0) report_error("accepted packets never delivered");
      expected.delete();
      to_send.delete();
      if (errors == errors_at_start) begin
         $display("test %s: passed", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, errors - errors_at_start);
      end
   endtask

   //########################################
   // APB master
   //########################################

   task automatic apb_access(input logic wr, input logic [`UMI_APB_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int waits;
      @(negedge clk);
      psel    = 1'b1;                   // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;                   // Access phase
      waits   = 0;
      #(HALF / 2);
      while (!pready && waits < TIMEOUT) begin
         @(negedge clk);
         #(HALF / 2);
         waits++;
      end
      if (!pready) report_error("APB pready never came");
      rdata       = prdata;
      last_slverr = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [`UMI_APB_AW-1:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_access(1'b1, addr, data, unused);
   endtask

   task automatic apb_read(input logic [`UMI_APB_AW-1:0] addr, output logic [31:0] data);
      apb_access(1'b0, addr, 32'd0, data);
   endtask

   // Poll STATUS until it reads want
   task automatic wait_status(input logic [31:0] want);
      logic [31:0] val;
      int          polls;
      polls = 0;
      apb_read(umi_pkg::CSR_STATUS, val);
      while (val !== want && polls < 20) begin
         apb_read(umi_pkg::CSR_STATUS, val);
         polls++;
      end
      check_word(want, val);
   endtask

   //########################################
   // UMI drivers
   //########################################

   // Offer each queued packet until taken
   task automatic send_all();
      int stall;
      stall = 0;
      while (to_send.size() > 0 && stall < TIMEOUT) begin
         @(negedge clk);
         umi_in_valid = 1'b1;
         umi_in_pkt   = to_send[0];
         if (umi_in_ready) begin      // Beat on the coming edge
            expected.push_back(to_send.pop_front());
            stall = 0;
         end else stall++;
      end
      if (to_send.size() > 0) report_error("input side stopped accepting packets");
      @(negedge clk);
      umi_in_valid = 1'b0;
   endtask

   // Send until umi_in_ready stays low, valid is left high on the pending packet
   task automatic fill_until_stall(output int accepted);
      int cycles;
      int stall_run;
      accepted  = 0;
      cycles    = 0;
      stall_run = 0;
      while (stall_run < STALL_RUN && cycles < TIMEOUT && to_send.size() > 0) begin
         @(negedge clk);
         umi_in_valid = 1'b1;
         umi_in_pkt   = to_send[0];
         if (umi_in_ready) begin
            expected.push_back(to_send.pop_front());
            accepted++;
            stall_run = 0;
         end else stall_run++;
         cycles++;
      end
      if (stall_run < STALL_RUN) report_error("umi_in_ready did not stay low under back-pressure");
   endtask

   task automatic recv_pkts(input int n, input logic random_ready);
      umi_pkg::umi_pkt_t exp_pkt;
      int                got;
      int                idle;
      got  = 0;
      idle = 0;
      while (got < n && idle < TIMEOUT) begin
         @(negedge clk);
         umi_out_ready = random_ready ? lfsr_bit() : 1'b1;
         if (umi_out_valid && umi_out_ready) begin
            if (expected.size() == 0) begin
               report_error("packet delivered that was never sent");
            end else begin
               exp_pkt = expected.pop_front();
               check_pkt(exp_pkt, umi_out_pkt);
            end
            got++;
            idle = 0;
         end else idle++;
      end
      if (got < n) report_error("timed out waiting for output packets");
      @(negedge clk);
      umi_out_ready = 1'b1;
   endtask

   //########################################
   // Tests
   //########################################

   task automatic reset_and_regs();
      logic [31:0] val;
      start_test("reset_and_regs");
      check_word(32'd0, {31'd0, umi_out_valid});
      check_word(32'd1, {31'd0, umi_in_ready});
      apb_read(umi_pkg::CSR_CTRL, val);
      check_word(32'd0, val);
      apb_read(umi_pkg::CSR_STATUS, val);
      check_word(32'h2, val);                       // Empty, not full
      apb_read(umi_pkg::CSR_CNT_REQ, val);
      check_word(32'd0, val);
      apb_read(umi_pkg::CSR_CNT_RESP, val);
      check_word(32'd0, val);
      apb_read(umi_pkg::CSR_CNT_OTHER, val);
      check_word(32'd0, val);
      apb_write(umi_pkg::CSR_CTRL, 32'h3);
      check_word(32'd0, {31'd0, last_slverr});
      apb_read(umi_pkg::CSR_CTRL, val);
      check_word(32'h3, val);
      apb_write(umi_pkg::CSR_CTRL, 32'h0);
      apb_read(8'h20, val);                         // Unmapped
      check_word(32'd1, {31'd0, last_slverr});
      apb_write(8'h20, 32'hffff_ffff);
      check_word(32'd1, {31'd0, last_slverr});
      apb_read(umi_pkg::CSR_CTRL, val);
      check_word(32'd0, val);                       // Unmapped write had no effect
      finish_test();
   endtask

   task automatic streaming();
      logic [63:0] op;
      start_test("streaming");
      for (int i = 0; i < 20; i++) begin
         op = rand_bits(8);
         to_send.push_back(make_pkt(op[7:0]));
      end
      fork
         send_all();
         recv_pkts(20, 1'b0);
      join
      finish_test();
   endtask

   task automatic back_pressure();
      int accepted;
      start_test("back_pressure");
      @(negedge clk);
      umi_out_ready = 1'b0;
      for (int i = 0; i < 12; i++) to_send.push_back(make_pkt(umi_pkg::UMI_REQ_WRITE));
      fill_until_stall(accepted);
      check_word(`UMI_FIFO_DEPTH + 2, accepted);    // FIFO entries plus two in the skid
      check_word(32'd0, {31'd0, umi_in_ready});
      wait_status(32'h1);                           // Full, not empty
      fork
         send_all();
         recv_pkts(12, 1'b0);
      join
      finish_test();
   endtask

   task automatic chaos_mode();
      start_test("chaos_mode");
      apb_write(umi_pkg::CSR_CTRL, 32'h2);
      for (int i = 0; i < 40; i++) to_send.push_back(make_pkt(umi_pkg::UMI_REQ_POSTED));
      fork
         send_all();
         recv_pkts(40, 1'b1);
      join
      apb_write(umi_pkg::CSR_CTRL, 32'h0);
      finish_test();
   endtask

   task automatic bypass_path();
      int accepted;
      start_test("bypass_path");
      @(negedge clk);
      umi_out_ready = 1'b0;
      apb_write(umi_pkg::CSR_CTRL, 32'h1);
      check_word(32'd1, {31'd0, umi_in_ready});     // Skid buffer empty
      for (int i = 0; i < 10; i++) to_send.push_back(make_pkt(umi_pkg::UMI_RESP_READ));
      fill_until_stall(accepted);
      check_word(32'd2, accepted);                  // Skid holds two, FIFO unused
      fork
         send_all();
         recv_pkts(10, 1'b1);
      join
      apb_write(umi_pkg::CSR_CTRL, 32'h0);
      finish_test();
   endtask

   task automatic opcode_counters();
      logic [31:0] val;
      start_test("opcode_counters");
      apb_write(umi_pkg::CSR_CNT_REQ, 32'h0);
      apb_write(umi_pkg::CSR_CNT_RESP, 32'h0);
      apb_write(umi_pkg::CSR_CNT_OTHER, 32'h0);
      apb_read(umi_pkg::CSR_CNT_REQ, val);
      check_word(32'd0, val);
      // Four requests, three responses, two others
      to_send.push_back(make_pkt(umi_pkg::UMI_REQ_READ));
      to_send.push_back(make_pkt(umi_pkg::UMI_RESP_READ));
      to_send.push_back(make_pkt(umi_pkg::UMI_REQ_WRITE));
      to_send.push_back(make_pkt(8'h00));
      to_send.push_back(make_pkt(umi_pkg::UMI_REQ_POSTED));
      to_send.push_back(make_pkt(umi_pkg::UMI_RESP_WRITE));
      to_send.push_back(make_pkt(8'h3c));
      to_send.push_back(make_pkt(umi_pkg::UMI_REQ_WRITE));
      to_send.push_back(make_pkt(umi_pkg::UMI_RESP_READ));
      fork
         send_all();
         recv_pkts(9, 1'b0);
      join
      apb_read(umi_pkg::CSR_CNT_REQ, val);
      check_word(32'd4, val);
      apb_read(umi_pkg::CSR_CNT_RESP, val);
      check_word(32'd3, val);
      apb_read(umi_pkg::CSR_CNT_OTHER, val);
      check_word(32'd2, val);
      apb_write(umi_pkg::CSR_CNT_RESP, 32'h1234);   // Any value clears
      apb_read(umi_pkg::CSR_CNT_RESP, val);
      check_word(32'd0, val);
      apb_read(umi_pkg::CSR_CNT_REQ, val);
      check_word(32'd4, val);                       // Others untouched
      finish_test();
   endtask

   //########################################
   // Main sequence
   //########################################

   initial begin
      clk           = 1'b0;
      rst_n         = 1'b0;
      umi_in_valid  = 1'b0;
      umi_in_pkt    = '0;
      umi_out_ready = 1'b1;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      lfsr_state    = 16'd92;
      last_slverr   = 1'b0;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      cur_test      = "reset";
      repeat (8) @(posedge clk);                    // Both domains see reset
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      reset_and_regs();
      streaming();
      back_pressure();
      chaos_mode();
      bypass_path();
      opcode_counters();
      $display("%0d tests run, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+.
umi_pkg.sv
umi_async_fifo.sv
umi_fifo.sv
umi_skid_buffer.sv
umi_fifo_csr.sv
umi_fifo_top.sv
tb_umi_fifo_assertions.sv
tb_umi_fifo.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the UMI FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_umi_fifo -f list.f -o tb_umi_fifo

./obj_dir/tb_umi_fifo | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
